// File: hw/cpu_mem_config.svh
`ifndef CPU_MEM_CONFIG_SVH
`define CPU_MEM_CONFIG_SVH

// Data and address width
`define XLEN 32

// Data RAM depth in words, a power of two
`define DMEM_WORDS 256

// Word index width into the data RAM
`define DMEM_ADDR_BITS $clog2(`DMEM_WORDS)

`endif

// File: hw/cpu_pkg.sv
package cpu_pkg;

	// Source of the value written back to the register file
	typedef enum logic [2:0] {
		SEL_ALU	= 3'd0,
		SEL_MEM	= 3'd1,
		SEL_CSR	= 3'd2,
		SEL_PC4	= 3'd3
	} wb_src_t;

	// Load and store opcodes
	typedef enum logic [2:0] {
		MEM_LB	= 3'd0,
		MEM_LH	= 3'd1,
		MEM_LW	= 3'd2,
		MEM_LBU	= 3'd3,
		MEM_LHU	= 3'd4,
		MEM_SB	= 3'd5,
		MEM_SH	= 3'd6,
		MEM_SW	= 3'd7
	} mem_op_t;

	typedef enum logic [1:0] {
		CSR_NONE	= 2'd0,
		CSR_RW		= 2'd1,
		CSR_RS		= 2'd2,
		CSR_RC		= 2'd3
	} csr_op_t;

	// Access fault on the data bus
	localparam logic [31:0] CAUSE_DMEM_BUS_ERROR = 32'h0000_0005;

endpackage

// File: hw/dmem_pkg.sv
package dmem_pkg;

	// Response code on the read and write response channels
	typedef enum logic [1:0] {
		RESP_OKAY	= 2'b00,
		RESP_EXOKAY	= 2'b01,
		RESP_SLVERR	= 2'b10,
		RESP_DECERR	= 2'b11
	} resp_t;

	// One enable per byte lane of a write
	typedef logic [3:0] strb_t;

endpackage

// File: hw/mem_issue.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module mem_issue
	import cpu_pkg::*, dmem_pkg::*;
(
	input	logic				clk,
	input	logic				reset,

	input	logic				valid_in,
	input	logic				ready_out,
	input	logic				flush_out,

	input	wb_src_t			wb_src_ex,
	input	mem_op_t			mem_op_ex,
	input	logic				rd_wena_ex,
	input	logic				exc_pend_ex,
	input	logic	[`XLEN-1:0]	mem_addr_ex,
	input	logic	[`XLEN-1:0]	store_data_ex,

	output	logic				arvalid,
	input	logic				arready,
	output	logic	[`XLEN-1:0]	araddr,
	output	logic				awvalid,
	input	logic				awready,
	output	logic	[`XLEN-1:0]	awaddr,
	output	logic	[`XLEN-1:0]	wdata,
	output	strb_t				wstrb
);

	logic			sent;		// Request of the current instruction already done
	logic			mem_req;
	logic			accept;
	logic	[1:0]	byte_off;

	assign byte_off	= mem_addr_ex[1:0];
	assign accept	= valid_in && ready_out && !flush_out;
	assign mem_req	= valid_in && wb_src_ex == SEL_MEM && !exc_pend_ex && !flush_out && !sent;

	assign arvalid	= mem_req && rd_wena_ex;	// Loads write rd
	assign awvalid	= mem_req && !rd_wena_ex;
	assign araddr	= mem_addr_ex;
	assign awaddr	= mem_addr_ex;
	assign wdata	= store_data_ex << (8 * byte_off);	// Move data onto its byte lanes

	always_comb begin
		case (mem_op_ex)
		MEM_SB:		wstrb = 4'b0001 << byte_off;
		MEM_SH:		wstrb = 4'b0011 << byte_off;
		MEM_SW:		wstrb = 4'b1111;
		default:	wstrb = 4'b0000;
		endcase
	end

	// Held until the stage takes the instruction
	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			sent <= 1'b0;
		else if (accept || flush_out)
			sent <= 1'b0;
		else if ((arvalid && arready) || (awvalid && awready))
			sent <= 1'b1;
	end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module mem_stage
	import cpu_pkg::*, dmem_pkg::*;
(
	input	logic				clk,
	input	logic				reset,

	input	logic				valid_in,
	output	logic				ready_out,
	output	logic				flush_out,
	output	logic				valid_out,
	input	logic				ready_in,
	input	logic				flush_in,
	input	logic				exc_taken_csr,

	input	logic	[`XLEN-1:0]	pc_ex,
	input	logic				rd_wena_ex,
	input	logic	[5:0]		rd_addr_ex,
	input	logic	[`XLEN-1:0]	rd_data_ex,
	input	logic	[11:0]		csr_addr_ex,
	input	logic				csr_rena_ex,
	input	logic				csr_wena_ex,
	input	logic	[`XLEN-1:0]	csr_wdata_ex,
	input	wb_src_t			wb_src_ex,
	input	mem_op_t			mem_op_ex,
	input	csr_op_t			csr_op_ex,
	input	logic				exc_pend_ex,
	input	logic	[31:0]		exc_cause_ex,

	input	logic	[1:0]		araddr_low,	// Byte offset of the load
	input	logic	[`XLEN-1:0]	rdata,
	input	resp_t				rresp,
	input	logic				rvalid,
	output	logic				rready,
	input	resp_t				bresp,
	input	logic				bvalid,
	output	logic				bready,

	output	logic	[`XLEN-1:0]	pc_mem,
	output	logic				rd_wena_mem,
	output	logic	[5:0]		rd_addr_mem,
	output	logic	[`XLEN-1:0]	rd_data_mem,
	output	logic	[11:0]		csr_addr_mem,
	output	logic				csr_rena_mem,
	output	logic				csr_wena_mem,
	output	logic	[`XLEN-1:0]	csr_wdata_mem,
	output	wb_src_t			wb_src_mem,
	output	csr_op_t			csr_op_mem,
	output	logic				exc_pend_mem,
	output	logic	[31:0]		exc_cause_mem
);

	logic				stall;
	logic				accept;
	logic				drain;
	logic				is_mem;		// Memory access that went out on the bus
	logic				mem_err;
	logic	[`XLEN-1:0]	rdata_aligned;
	logic	[`XLEN-1:0]	rdata_ext;

	assign is_mem		= wb_src_ex == SEL_MEM && !exc_pend_ex;
	assign mem_err		= is_mem && (rd_wena_ex ? rresp != RESP_OKAY : bresp != RESP_OKAY);

	// Hold while an exception or CSR access sits in MEM or the response is missing
	assign stall		= exc_pend_mem || csr_wena_mem || csr_rena_mem ||
						  (is_mem && (rd_wena_ex ? !rvalid : !bvalid));

	assign ready_out	= ready_in && !stall;
	assign flush_out	= flush_in || exc_taken_csr;
	assign accept		= valid_in && ready_out && !flush_out;
	assign drain		= valid_out && ready_in;

	assign rready		= is_mem &&  rd_wena_ex && valid_in && ready_out;
	assign bready		= is_mem && !rd_wena_ex && valid_in && ready_out;

	assign rdata_aligned	= rdata >> (8 * araddr_low);

	always_comb begin
		case (mem_op_ex)
		MEM_LB:		rdata_ext = {{24{rdata_aligned[7]}}, rdata_aligned[7:0]};
		MEM_LBU:	rdata_ext = {24'h000000, rdata_aligned[7:0]};
		MEM_LH:		rdata_ext = {{16{rdata_aligned[15]}}, rdata_aligned[15:0]};
		MEM_LHU:	rdata_ext = {16'h0000, rdata_aligned[15:0]};
		default:	rdata_ext = rdata_aligned;
		endcase
	end

	// Control part of the MEM/WB register
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out		<= 1'b0;
			rd_wena_mem		<= 1'b0;
			csr_rena_mem	<= 1'b0;
			csr_wena_mem	<= 1'b0;
			exc_pend_mem	<= 1'b0;
		end
		else if (flush_in) begin
			valid_out		<= 1'b0;
			rd_wena_mem		<= 1'b0;
			csr_rena_mem	<= 1'b0;
			csr_wena_mem	<= 1'b0;
			exc_pend_mem	<= 1'b0;
		end
		else if (accept) begin
			valid_out		<= 1'b1;
			rd_wena_mem		<= rd_wena_ex;
			csr_rena_mem	<= csr_rena_ex;
			csr_wena_mem	<= csr_wena_ex;
			exc_pend_mem	<= exc_pend_ex || mem_err;
		end
		else if (drain) begin
			valid_out		<= 1'b0;
			rd_wena_mem		<= 1'b0;
			csr_rena_mem	<= 1'b0;
			csr_wena_mem	<= 1'b0;
			exc_pend_mem	<= 1'b0;
		end
	end

	// Data part, qualified by valid_out
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_mem			<= pc_ex;
			rd_addr_mem		<= rd_addr_ex;
			csr_addr_mem	<= csr_addr_ex;
			csr_wdata_mem	<= csr_wdata_ex;
			wb_src_mem		<= wb_src_ex;
			csr_op_mem		<= csr_op_ex;

			// Faulting load keeps the execute value
			if (is_mem && rd_wena_ex && !mem_err)
				rd_data_mem	<= rdata_ext;
			else
				rd_data_mem	<= rd_data_ex;

			exc_cause_mem	<= mem_err ? CAUSE_DMEM_BUS_ERROR : exc_cause_ex;
		end
	end

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module data_ram
	import dmem_pkg::*;
(
	input	logic				clk,
	input	logic				reset,

	input	logic				arvalid,
	output	logic				arready,
	input	logic	[`XLEN-1:0]	araddr,

	input	logic				awvalid,
	output	logic				awready,
	input	logic	[`XLEN-1:0]	awaddr,
	input	logic	[`XLEN-1:0]	wdata,
	input	strb_t				wstrb,

	output	logic				rvalid,
	input	logic				rready,
	output	logic	[`XLEN-1:0]	rdata,
	output	resp_t				rresp,

	output	logic				bvalid,
	input	logic				bready,
	output	resp_t				bresp
);

	localparam int LANES = $bits(strb_t);

	logic	[`XLEN-1:0]				mem [`DMEM_WORDS];

	logic							ar_hit;
	logic							aw_hit;
	logic							ar_in_range;
	logic							aw_in_range;
	logic	[`DMEM_ADDR_BITS-1:0]	ar_index;
	logic	[`DMEM_ADDR_BITS-1:0]	aw_index;

	assign ar_index		= araddr[`DMEM_ADDR_BITS+1:2];
	assign aw_index		= awaddr[`DMEM_ADDR_BITS+1:2];
	assign ar_in_range	= araddr[`XLEN-1:`DMEM_ADDR_BITS+2] == '0;	// Word address below depth
	assign aw_in_range	= awaddr[`XLEN-1:`DMEM_ADDR_BITS+2] == '0;

	// One outstanding response at a time
	assign arready	= !rvalid && !bvalid;
	assign awready	= !rvalid && !bvalid;
	assign ar_hit	= arvalid && arready;
	assign aw_hit	= awvalid && awready;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rvalid	<= 1'b0;
			bvalid	<= 1'b0;
		end
		else begin
			if (ar_hit)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (aw_hit)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Response payload, held until taken
	always_ff @(posedge clk) begin
		if (ar_hit) begin
			rdata	<= ar_in_range ? mem[ar_index] : '0;
			rresp	<= ar_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (aw_hit)
			bresp	<= aw_in_range ? RESP_OKAY : RESP_SLVERR;
	end

	always_ff @(posedge clk) begin
		if (aw_hit && aw_in_range) begin
			for (int i = 0; i < LANES; i++) begin
				if (wstrb[i])
					mem[aw_index][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

endmodule

// File: hw/mem_subsystem.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module mem_subsystem
	import cpu_pkg::*, dmem_pkg::*;
(
	input	logic				clk,
	input	logic				reset,

	input	logic				valid_in,
	output	logic				ready_out,
	output	logic				flush_out,
	output	logic				valid_out,
	input	logic				ready_in,
	input	logic				flush_in,
	input	logic				exc_taken_csr,

	input	logic	[`XLEN-1:0]	pc_ex,
	input	logic				rd_wena_ex,
	input	logic	[5:0]		rd_addr_ex,
	input	logic	[`XLEN-1:0]	rd_data_ex,
	input	logic	[`XLEN-1:0]	store_data_ex,
	input	logic	[`XLEN-1:0]	mem_addr_ex,
	input	wb_src_t			wb_src_ex,
	input	mem_op_t			mem_op_ex,
	input	logic	[11:0]		csr_addr_ex,
	input	logic				csr_rena_ex,
	input	logic				csr_wena_ex,
	input	logic	[`XLEN-1:0]	csr_wdata_ex,
	input	csr_op_t			csr_op_ex,
	input	logic				exc_pend_ex,
	input	logic	[31:0]		exc_cause_ex,

	output	logic	[`XLEN-1:0]	pc_mem,
	output	logic				rd_wena_mem,
	output	logic	[5:0]		rd_addr_mem,
	output	logic	[`XLEN-1:0]	rd_data_mem,
	output	logic	[11:0]		csr_addr_mem,
	output	logic				csr_rena_mem,
	output	logic				csr_wena_mem,
	output	logic	[`XLEN-1:0]	csr_wdata_mem,
	output	wb_src_t			wb_src_mem,
	output	csr_op_t			csr_op_mem,
	output	logic				exc_pend_mem,
	output	logic	[31:0]		exc_cause_mem
);

	// Request channels
	logic				arvalid, arready, awvalid, awready;
	logic	[`XLEN-1:0]	araddr, awaddr, wdata;
	strb_t				wstrb;

	// Response channels
	logic				rvalid, rready, bvalid, bready;
	logic	[`XLEN-1:0]	rdata;
	resp_t				rresp, bresp;

	mem_issue mem_issue_i (
		.clk			(clk),
		.reset			(reset),
		.valid_in		(valid_in),
		.ready_out		(ready_out),
		.flush_out		(flush_out),
		.wb_src_ex		(wb_src_ex),
		.mem_op_ex		(mem_op_ex),
		.rd_wena_ex		(rd_wena_ex),
		.exc_pend_ex	(exc_pend_ex),
		.mem_addr_ex	(mem_addr_ex),
		.store_data_ex	(store_data_ex),
		.arvalid		(arvalid),
		.arready		(arready),
		.araddr			(araddr),
		.awvalid		(awvalid),
		.awready		(awready),
		.awaddr			(awaddr),
		.wdata			(wdata),
		.wstrb			(wstrb)
	);

	mem_stage mem_stage_i (
		.clk			(clk),
		.reset			(reset),
		.valid_in		(valid_in),
		.ready_out		(ready_out),
		.flush_out		(flush_out),
		.valid_out		(valid_out),
		.ready_in		(ready_in),
		.flush_in		(flush_in),
		.exc_taken_csr	(exc_taken_csr),
		.pc_ex			(pc_ex),
		.rd_wena_ex		(rd_wena_ex),
		.rd_addr_ex		(rd_addr_ex),
		.rd_data_ex		(rd_data_ex),
		.csr_addr_ex	(csr_addr_ex),
		.csr_rena_ex	(csr_rena_ex),
		.csr_wena_ex	(csr_wena_ex),
		.csr_wdata_ex	(csr_wdata_ex),
		.wb_src_ex		(wb_src_ex),
		.mem_op_ex		(mem_op_ex),
		.csr_op_ex		(csr_op_ex),
		.exc_pend_ex	(exc_pend_ex),
		.exc_cause_ex	(exc_cause_ex),
		.araddr_low		(araddr[1:0]),
		.rdata			(rdata),
		.rresp			(rresp),
		.rvalid			(rvalid),
		.rready			(rready),
		.bresp			(bresp),
		.bvalid			(bvalid),
		.bready			(bready),
		.pc_mem			(pc_mem),
		.rd_wena_mem	(rd_wena_mem),
		.rd_addr_mem	(rd_addr_mem),
		.rd_data_mem	(rd_data_mem),
		.csr_addr_mem	(csr_addr_mem),
		.csr_rena_mem	(csr_rena_mem),
		.csr_wena_mem	(csr_wena_mem),
		.csr_wdata_mem	(csr_wdata_mem),
		.wb_src_mem		(wb_src_mem),
		.csr_op_mem		(csr_op_mem),
		.exc_pend_mem	(exc_pend_mem),
		.exc_cause_mem	(exc_cause_mem)
	);

	data_ram data_ram_i (
		.clk		(clk),
		.reset		(reset),
		.arvalid	(arvalid),
		.arready	(arready),
		.araddr		(araddr),
		.awvalid	(awvalid),
		.awready	(awready),
		.awaddr		(awaddr),
		.wdata		(wdata),
		.wstrb		(wstrb),
		.rvalid		(rvalid),
		.rready		(rready),
		.rdata		(rdata),
		.rresp		(rresp),
		.bvalid		(bvalid),
		.bready		(bready),
		.bresp		(bresp)
	);

endmodule

// File: testbench/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
	import cpu_pkg::*;
();

	localparam int MAX_LINES = 64;

	logic			clk;
	logic			reset;
	logic			valid_in;
	logic			ready_out;
	logic			flush_out;
	logic			valid_out;
	logic			ready_in;
	logic			flush_in;
	logic			exc_taken_csr;
	logic	[31:0]	pc_ex;
	logic			rd_wena_ex;
	logic	[5:0]	rd_addr_ex;
	logic	[31:0]	rd_data_ex;
	logic	[31:0]	store_data_ex;
	logic	[31:0]	mem_addr_ex;
	wb_src_t		wb_src_ex;
	mem_op_t		mem_op_ex;
	logic	[11:0]	csr_addr_ex;
	logic			csr_rena_ex;
	logic			csr_wena_ex;
	logic	[31:0]	csr_wdata_ex;
	csr_op_t		csr_op_ex;
	logic			exc_pend_ex;
	logic	[31:0]	exc_cause_ex;
	logic	[31:0]	pc_mem;
	logic			rd_wena_mem;
	logic	[5:0]	rd_addr_mem;
	logic	[31:0]	rd_data_mem;
	logic	[11:0]	csr_addr_mem;
	logic			csr_rena_mem;
	logic			csr_wena_mem;
	logic	[31:0]	csr_wdata_mem;
	wb_src_t		wb_src_mem;
	csr_op_t		csr_op_mem;
	logic			exc_pend_mem;
	logic	[31:0]	exc_cause_mem;

	// One entry per line of the input file
	mem_op_t		t_op [MAX_LINES];
	wb_src_t		t_wb [MAX_LINES];
	logic			t_wena [MAX_LINES];
	logic	[31:0]	t_addr [MAX_LINES];
	logic	[31:0]	t_data [MAX_LINES];
	logic			t_flush [MAX_LINES];
	int				t_stall [MAX_LINES];
	logic	[31:0]	t_exp_data [MAX_LINES];
	logic			t_exp_pend [MAX_LINES];
	logic	[31:0]	t_exp_cause [MAX_LINES];

	int				n_tests = 0;
	int				errors = 0;
	int				passed = 0;
	int				cycle_limit = 0;
	int				cycle_count = 0;
	logic	[31:0]	lfsr;

	mem_subsystem mem_subsystem_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32 22 2 1
	endfunction

	function automatic logic [31:0] pc_for_test(input int t);
		return 32'h0000_1000 + 32'(4 * t);
	endfunction

	function automatic logic [11:0] csr_addr_for_test(input int t);
		return 12'h300 + 12'(t);
	endfunction

	task automatic draw_extra_stall(output int extra);
		extra = 0;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_next(lfsr);
			extra = (extra << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_exc(input logic exp_pend, input logic [31:0] exp_cause,
			input logic act_pend, input logic [31:0] act_cause);
		if (act_pend !== exp_pend) begin
			$display("FAILED exc_pend_mem expected %h got %h", exp_pend, act_pend);
			errors++;
		end
		if (act_cause !== exp_cause) begin
			$display("FAILED exc_cause_mem expected %h got %h", exp_cause, act_cause);
			errors++;
		end
	endtask

	task automatic check_wb_src(input wb_src_t exp, input wb_src_t act);
		if (act !== exp) begin
			$display("FAILED wb_src_mem expected %h got %h", exp, act);
			errors++;
		end
	endtask

	task automatic check_csr_op(input csr_op_t exp, input csr_op_t act);
		if (act !== exp) begin
			$display("FAILED csr_op_mem expected %h got %h", exp, act);
			errors++;
		end
	endtask

	// Every MEM/WB field against what test t put into the stage
	task automatic compare_stage_outputs(input int t);
		check_data("rd_data_mem", t_exp_data[t], rd_data_mem);
		check_exc(t_exp_pend[t], t_exp_cause[t], exc_pend_mem, exc_cause_mem);
		check_wb_src(t_wb[t], wb_src_mem);
		check_data("pc_mem", pc_for_test(t), pc_mem);
		check_data("rd_addr_mem", {26'h0, 6'(t)}, {26'h0, rd_addr_mem});
		check_flag("rd_wena_mem", t_wena[t], rd_wena_mem);
		check_data("csr_addr_mem", {20'h0, csr_addr_for_test(t)}, {20'h0, csr_addr_mem});
		check_data("csr_wdata_mem", ~t_data[t], csr_wdata_mem);
		check_flag("csr_rena_mem", 1'b0, csr_rena_mem);
		check_flag("csr_wena_mem", 1'b0, csr_wena_mem);
		check_csr_op(csr_op_t'(t[1:0]), csr_op_mem);
	endtask

	task automatic read_tests();
		int				fd;
		int				n;
		int				stall;
		string			line;
		logic	[31:0]	op, wb, wena, addr, data, fl, ed, ep, ec;
		fd = $fopen("testbench/mem_subsystem_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the input file");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %d %h %h %h",
				op, wb, wena, addr, data, fl, stall, ed, ep, ec);
			if (n == 10 && n_tests < MAX_LINES) begin
				t_op[n_tests]			= mem_op_t'(op[2:0]);
				t_wb[n_tests]			= wb_src_t'(wb[2:0]);
				t_wena[n_tests]			= wena[0];
				t_addr[n_tests]			= addr;
				t_data[n_tests]			= data;
				t_flush[n_tests]		= fl[0];
				t_stall[n_tests]		= stall;
				t_exp_data[n_tests]		= ed;
				t_exp_pend[n_tests]		= ep[0];
				t_exp_cause[n_tests]	= ec;
				n_tests++;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int t);
		int				stalls;
		int				waited;
		int				errs_before;
		errs_before = errors;
		draw_extra_stall(stalls);
		stalls += t_stall[t];
		@(posedge clk);
		mem_op_ex		<= t_op[t];
		wb_src_ex		<= t_wb[t];
		rd_wena_ex		<= t_wena[t];
		mem_addr_ex		<= t_addr[t];
		store_data_ex	<= t_data[t];
		rd_data_ex		<= (t_wb[t] == SEL_MEM) ? t_addr[t] : t_data[t];	// Stores carry the address
		pc_ex			<= pc_for_test(t);
		rd_addr_ex		<= 6'(t);
		csr_addr_ex		<= csr_addr_for_test(t);
		csr_wdata_ex	<= ~t_data[t];
		csr_op_ex		<= csr_op_t'(t[1:0]);
		flush_in		<= t_flush[t];
		valid_in		<= 1'b1;
		ready_in		<= 1'b1;
		if (t_flush[t]) begin
			@(negedge clk);
			check_flag("flush_out", 1'b1, flush_out);
			@(posedge clk);
			valid_in	<= 1'b0;
			flush_in	<= 1'b0;
			for (int k = 0; k < 4; k++) begin
				@(negedge clk);
				if (valid_out) begin
					$display("Test %0d flushed instruction reached valid_out", t);
					errors++;
				end
			end
		end
		else begin
			@(negedge clk);
			check_flag("flush_out", 1'b0, flush_out);
			while (!(ready_out && !flush_out))
				@(negedge clk);
			@(posedge clk);		// Accepted here
			valid_in	<= 1'b0;
			ready_in	<= (stalls == 0);
			waited = 0;
			@(negedge clk);
			while (!valid_out && waited < 4) begin
				@(negedge clk);
				waited++;
			end
			if (!valid_out) begin
				$display("Test %0d valid_out never rose after acceptance", t);
				errors++;
			end
			else begin
				compare_stage_outputs(t);
				// Output must hold while ready_in is low
				for (int k = 0; k < stalls; k++) begin
					@(posedge clk);
					if (k == stalls - 1)
						ready_in <= 1'b1;
					@(negedge clk);
					if (!valid_out) begin
						$display("Test %0d valid_out dropped under back-pressure", t);
						errors++;
					end
					compare_stage_outputs(t);
				end
				@(negedge clk);
				if (valid_out) begin
					$display("Test %0d instruction left valid_out high after draining", t);
					errors++;
				end
			end
		end
		if (errors == errs_before)
			passed++;
		$display("test %0d %s addr %h stalls %0d %s", t, t_op[t].name(), t_addr[t], stalls,
			(errors == errs_before) ? "ok" : "fail");
	endtask

	// Watchdog on the whole run
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run stopped after %0d cycles without finishing", cycle_count);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int max_stall;
		reset			= 1'b1;
		valid_in		= 1'b0;
		ready_in		= 1'b1;
		flush_in		= 1'b0;
		exc_taken_csr	= 1'b0;
		pc_ex			= '0;
		rd_wena_ex		= 1'b0;
		rd_addr_ex		= '0;
		rd_data_ex		= '0;
		store_data_ex	= '0;
		mem_addr_ex		= '0;
		wb_src_ex		= SEL_ALU;
		mem_op_ex		= MEM_LW;
		csr_addr_ex		= '0;
		csr_rena_ex		= 1'b0;
		csr_wena_ex		= 1'b0;
		csr_wdata_ex	= '0;
		csr_op_ex		= CSR_NONE;
		exc_pend_ex		= 1'b0;
		exc_cause_ex	= '0;
		lfsr			= 32'hbd15_35f9;
		read_tests();
		max_stall = 0;
		for (int i = 0; i < n_tests; i++)
			if (t_stall[i] > max_stall)
				max_stall = t_stall[i];
		max_stall += 3;		// Largest random extra
		cycle_limit = (n_tests > 0) ? n_tests * (4 + max_stall + 8) + 4 : 16;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		if (n_tests == 0) begin
			$display("No test lines were read");
			errors++;
		end
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("Tests %0d passed %0d failed %0d errors %0d",
			n_tests, passed, n_tests - passed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: cpu_mem.f
+incdir+hw
hw/cpu_pkg.sv
hw/dmem_pkg.sv
hw/mem_issue.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/mem_subsystem.sv
testbench/mem_subsystem_tb.sv

// File: Makefile
SIM      = verilator
TOP      = mem_subsystem_tb
FILELIST = cpu_mem.f
OBJDIR   = obj_dir
FLAGS    = --binary --top-module $(TOP) --Mdir $(OBJDIR)
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
PASS     = All checks passed

SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS  = hw/cpu_mem_config.svh

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

check:
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: testbench/mem_subsystem_input.txt
# Columns op wb wena addr data flush stall exp_data exp_pend exp_cause with stall in decimal
# Op 0 LB 1 LH 2 LW 3 LBU 4 LHU 5 SB 6 SH 7 SW and wb 0 ALU 1 MEM
7 1 0 00000010 12345678 0 0 00000010 0 00000000
2 1 1 00000010 00000000 0 2 12345678 0 00000000
7 1 0 00000020 cafef00d 0 0 00000020 0 00000000
5 1 0 00000021 000000a5 0 1 00000021 0 00000000
6 1 0 00000022 00008123 0 0 00000022 0 00000000
5 1 0 00000023 000000fe 0 3 00000023 0 00000000
2 1 1 00000020 00000000 0 0 fe23a50d 0 00000000
0 1 1 00000020 00000000 0 1 0000000d 0 00000000
0 1 1 00000021 00000000 0 0 ffffffa5 0 00000000
3 1 1 00000021 00000000 0 2 000000a5 0 00000000
0 1 1 00000022 00000000 0 0 00000023 0 00000000
0 1 1 00000023 00000000 0 0 fffffffe 0 00000000
3 1 1 00000023 00000000 0 1 000000fe 0 00000000
1 1 1 00000020 00000000 0 0 ffffa50d 0 00000000
4 1 1 00000020 00000000 0 3 0000a50d 0 00000000
1 1 1 00000022 00000000 0 0 fffffe23 0 00000000
4 1 1 00000022 00000000 0 0 0000fe23 0 00000000
7 1 0 00000000 11223344 0 0 00000000 0 00000000
7 1 0 00000400 deadbeef 0 2 00000400 1 00000005
2 1 1 00000000 00000000 0 0 11223344 0 00000000
2 1 1 00000404 00000000 0 0 00000404 1 00000005
2 1 1 00010010 00000000 0 1 00010010 1 00000005
2 0 1 00000010 00000abc 0 0 00000abc 0 00000000
7 0 0 00000010 55aa55aa 0 2 55aa55aa 0 00000000
2 1 1 00000010 00000000 0 0 12345678 0 00000000
7 1 0 00000010 deaddead 1 0 00000000 0 00000000
2 1 1 00000010 00000000 0 1 12345678 0 00000000
2 1 1 00000020 00000000 1 0 00000000 0 00000000
2 1 1 00000020 00000000 0 0 fe23a50d 0 00000000
